//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

  localparam int xlen = 32;
  localparam int csr_num_w = 14;
  localparam int ecode_w = 6;
  localparam int esubcode_w = 9;
  localparam int lie_w = 13;

  // csr numbers
  localparam logic [csr_num_w-1:0] csr_crmd = 14'h0;
  localparam logic [csr_num_w-1:0] csr_prmd = 14'h1;
  localparam logic [csr_num_w-1:0] csr_ecfg = 14'h4;
  localparam logic [csr_num_w-1:0] csr_estat = 14'h5;
  localparam logic [csr_num_w-1:0] csr_era = 14'h6;
  localparam logic [csr_num_w-1:0] csr_badv = 14'h7;
  localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
  localparam logic [csr_num_w-1:0] csr_save0 = 14'h30;
  localparam logic [csr_num_w-1:0] csr_save1 = 14'h31;
  localparam logic [csr_num_w-1:0] csr_save2 = 14'h32;
  localparam logic [csr_num_w-1:0] csr_save3 = 14'h33;
  localparam logic [csr_num_w-1:0] csr_tid = 14'h40;
  localparam logic [csr_num_w-1:0] csr_tcfg = 14'h41;
  localparam logic [csr_num_w-1:0] csr_tval = 14'h42;
  localparam logic [csr_num_w-1:0] csr_ticlr = 14'h44;

  // address error codes, the only ones that load badv
  localparam logic [ecode_w-1:0] ecode_adef = 6'h8;
  localparam logic [ecode_w-1:0] ecode_ale = 6'h9;

  localparam logic [xlen-1:0] crmd_reset = 32'h0000_0008; // da set
  localparam logic [lie_w-1:0] ecfg_lie_mask = 13'h1bff; // bit 10 reserved
  localparam logic [xlen-1:0] tval_idle = 32'hffff_ffff; // timer stopped

  function automatic logic [xlen-1:0] masked_merge(
    input logic [xlen-1:0] old_value,
    input logic [xlen-1:0] new_value,
    input logic [xlen-1:0] mask
  );
    return (new_value & mask) | (old_value & ~mask);
  endfunction

endpackage

`default_nettype wire

//--- src/csr_mode_regs.sv
`timescale 1ns/1ns
`default_nettype none

module csr_mode_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [csr_pkg::csr_num_w-1:0] csr_num,
  input  logic                          csr_we,
  input  logic [csr_pkg::xlen-1:0]      csr_wvalue,
  input  logic [csr_pkg::xlen-1:0]      csr_wmask,
  input  logic                          wb_ex,
  input  logic                          ertn_flush,
  input  logic                          timer_int,
  output logic [1:0]                    crmd_plv,
  output logic                          crmd_ie,
  output logic                          crmd_da,
  output logic                          crmd_pg,
  output logic [1:0]                    crmd_datf,
  output logic [1:0]                    crmd_datm,
  output logic [1:0]                    prmd_pplv,
  output logic                          prmd_pie,
  output logic [csr_pkg::lie_w-1:0]     ecfg_lie,
  output logic [1:0]                    estat_is_sw,
  output logic                          has_int
);

  logic [csr_pkg::xlen-1:0] crmd_wdata;
  logic [csr_pkg::xlen-1:0] prmd_wdata;
  logic [csr_pkg::xlen-1:0] ecfg_wdata;
  logic [csr_pkg::xlen-1:0] estat_wdata;
  logic [csr_pkg::lie_w-1:0] int_pend;

  assign crmd_wdata = csr_pkg::masked_merge({23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                             crmd_ie, crmd_plv}, csr_wvalue, csr_wmask);
  assign prmd_wdata = csr_pkg::masked_merge({29'b0, prmd_pie, prmd_pplv}, csr_wvalue, csr_wmask);
  assign ecfg_wdata = csr_pkg::masked_merge({19'b0, ecfg_lie}, csr_wvalue, csr_wmask);
  assign estat_wdata = csr_pkg::masked_merge({30'b0, estat_is_sw}, csr_wvalue, csr_wmask);

  always_ff @(posedge clk) begin
    if (reset) begin
      {crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv} <= csr_pkg::crmd_reset[8:0];
    end else if (wb_ex) begin
      crmd_plv <= 2'b0; // enter kernel, interrupts off
      crmd_ie <= 1'b0;
    end else if (ertn_flush) begin
      crmd_plv <= prmd_pplv;
      crmd_ie <= prmd_pie;
    end else if (csr_we && csr_num == csr_pkg::csr_crmd) begin
      {crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv} <= crmd_wdata[8:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prmd_pplv <= 2'b0;
      prmd_pie <= 1'b0;
    end else if (wb_ex) begin
      prmd_pplv <= crmd_plv;
      prmd_pie <= crmd_ie;
    end else if (csr_we && csr_num == csr_pkg::csr_prmd) begin
      prmd_pplv <= prmd_wdata[1:0];
      prmd_pie <= prmd_wdata[2];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ecfg_lie <= '0;
      estat_is_sw <= 2'b0;
    end else if (csr_we) begin
      if (csr_num == csr_pkg::csr_ecfg)
        ecfg_lie <= ecfg_wdata[csr_pkg::lie_w-1:0] & csr_pkg::ecfg_lie_mask;
      if (csr_num == csr_pkg::csr_estat)
        estat_is_sw <= estat_wdata[1:0]; // only sw bits writable
    end
  end

  // no ipi or hw lines in this core
  assign int_pend = {1'b0, timer_int, 1'b0, 8'b0, estat_is_sw};
  assign has_int = crmd_ie && (|(int_pend & ecfg_lie));

endmodule

`default_nettype wire

//--- src/csr_exc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module csr_exc_regs (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
  input  logic                           csr_we,
  input  logic [csr_pkg::xlen-1:0]       csr_wvalue,
  input  logic [csr_pkg::xlen-1:0]       csr_wmask,
  input  logic                           wb_ex,
  input  logic                           ertn_flush,
  input  logic [csr_pkg::ecode_w-1:0]    wb_ecode,
  input  logic [csr_pkg::esubcode_w-1:0] wb_esubcode,
  input  logic [csr_pkg::xlen-1:0]       wb_pc,
  input  logic [csr_pkg::xlen-1:0]       wb_badv,
  input  logic                           exc_if,
  output logic [csr_pkg::ecode_w-1:0]    estat_ecode,
  output logic [csr_pkg::esubcode_w-1:0] estat_esubcode,
  output logic [csr_pkg::xlen-1:0]       era,
  output logic [csr_pkg::xlen-1:0]       eentry,
  output logic [csr_pkg::xlen-1:0]       badv,
  output logic [csr_pkg::xlen-1:0]       save0,
  output logic [csr_pkg::xlen-1:0]       save1,
  output logic [csr_pkg::xlen-1:0]       save2,
  output logic [csr_pkg::xlen-1:0]       save3,
  output logic                           csr_is_branch,
  output logic [csr_pkg::xlen-1:0]       csr_pc_if
);

  logic [csr_pkg::xlen-1:0] save_q [4];
  logic [csr_pkg::xlen-1:0] eentry_wdata;
  logic                     addr_err;
  logic                     save_we;

  assign addr_err = (wb_ecode == csr_pkg::ecode_adef) || (wb_ecode == csr_pkg::ecode_ale);
  assign eentry_wdata = csr_pkg::masked_merge(eentry, csr_wvalue, csr_wmask);
  // save0..3 sit on four consecutive numbers
  assign save_we = csr_we &&
                   (csr_num[csr_pkg::csr_num_w-1:2] == csr_pkg::csr_save0[csr_pkg::csr_num_w-1:2]);

  always_ff @(posedge clk) begin
    if (reset) begin
      estat_ecode <= '0;
      estat_esubcode <= '0;
    end else if (wb_ex) begin
      estat_ecode <= wb_ecode;
      estat_esubcode <= wb_esubcode;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      era <= '0;
    end else if (wb_ex) begin
      era <= wb_pc;
    end else if (csr_we && csr_num == csr_pkg::csr_era) begin
      era <= csr_pkg::masked_merge(era, csr_wvalue, csr_wmask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      eentry <= '0;
    else if (csr_we && csr_num == csr_pkg::csr_eentry)
      eentry <= {eentry_wdata[csr_pkg::xlen-1:6], 6'b0}; // 64-byte aligned
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      badv <= '0;
    end else if (wb_ex && addr_err) begin
      badv <= exc_if ? wb_pc : wb_badv; // fetch fault reports the pc
    end else if (csr_we && csr_num == csr_pkg::csr_badv) begin
      badv <= csr_pkg::masked_merge(badv, csr_wvalue, csr_wmask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++)
        save_q[i] <= '0;
    end else if (save_we) begin
      save_q[csr_num[1:0]] <= csr_pkg::masked_merge(save_q[csr_num[1:0]], csr_wvalue, csr_wmask);
    end
  end

  assign save0 = save_q[0];
  assign save1 = save_q[1];
  assign save2 = save_q[2];
  assign save3 = save_q[3];

  assign csr_is_branch = wb_ex || ertn_flush;
  assign csr_pc_if = wb_ex      ? eentry :
                     ertn_flush ? era :
                     wb_pc + 32'd4;

endmodule

`default_nettype wire

//--- src/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_timer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [csr_pkg::csr_num_w-1:0] csr_num,
  input  logic                          csr_we,
  input  logic [csr_pkg::xlen-1:0]      csr_wvalue,
  input  logic [csr_pkg::xlen-1:0]      csr_wmask,
  output logic [csr_pkg::xlen-1:0]      tid,
  output logic                          tcfg_en,
  output logic                          tcfg_periodic,
  output logic [csr_pkg::xlen-3:0]      tcfg_initval,
  output logic [csr_pkg::xlen-1:0]      tval,
  output logic                          timer_int
);

  logic [csr_pkg::xlen-1:0] tcfg_wdata;
  logic                     tcfg_we;
  logic                     ticlr_clr;
  logic                     cnt_zero;

  assign tcfg_we = csr_we && (csr_num == csr_pkg::csr_tcfg);
  assign tcfg_wdata = csr_pkg::masked_merge({tcfg_initval, tcfg_periodic, tcfg_en},
                                            csr_wvalue, csr_wmask);
  assign ticlr_clr = csr_we && (csr_num == csr_pkg::csr_ticlr) && csr_wvalue[0] && csr_wmask[0];
  assign cnt_zero = (tval == '0);

  always_ff @(posedge clk) begin
    if (reset)
      tid <= '0;
    else if (csr_we && csr_num == csr_pkg::csr_tid)
      tid <= csr_pkg::masked_merge(tid, csr_wvalue, csr_wmask);
  end

  always_ff @(posedge clk) begin
    if (reset)
      {tcfg_initval, tcfg_periodic, tcfg_en} <= '0;
    else if (tcfg_we)
      {tcfg_initval, tcfg_periodic, tcfg_en} <= tcfg_wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tval <= csr_pkg::tval_idle;
    end else if (tcfg_we && tcfg_wdata[0]) begin
      tval <= {tcfg_wdata[csr_pkg::xlen-1:2], 2'b0}; // start from initval
    end else if (tcfg_en && tval != csr_pkg::tval_idle) begin
      if (cnt_zero)
        tval <= tcfg_periodic ? {tcfg_initval, 2'b0} : csr_pkg::tval_idle;
      else
        tval <= tval - 32'd1;
    end
  end

  // sticky until ticlr, expiry wins
  always_ff @(posedge clk) begin
    if (reset)
      timer_int <= 1'b0;
    else if (tcfg_en && cnt_zero)
      timer_int <= 1'b1;
    else if (ticlr_clr)
      timer_int <= 1'b0;
  end

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux (
  input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
  input  logic [1:0]                     crmd_plv,
  input  logic                           crmd_ie,
  input  logic                           crmd_da,
  input  logic                           crmd_pg,
  input  logic [1:0]                     crmd_datf,
  input  logic [1:0]                     crmd_datm,
  input  logic [1:0]                     prmd_pplv,
  input  logic                           prmd_pie,
  input  logic [csr_pkg::lie_w-1:0]      ecfg_lie,
  input  logic [1:0]                     estat_is_sw,
  input  logic                           timer_int,
  input  logic [csr_pkg::ecode_w-1:0]    estat_ecode,
  input  logic [csr_pkg::esubcode_w-1:0] estat_esubcode,
  input  logic [csr_pkg::xlen-1:0]       era,
  input  logic [csr_pkg::xlen-1:0]       eentry,
  input  logic [csr_pkg::xlen-1:0]       badv,
  input  logic [csr_pkg::xlen-1:0]       save0,
  input  logic [csr_pkg::xlen-1:0]       save1,
  input  logic [csr_pkg::xlen-1:0]       save2,
  input  logic [csr_pkg::xlen-1:0]       save3,
  input  logic [csr_pkg::xlen-1:0]       tid,
  input  logic                           tcfg_en,
  input  logic                           tcfg_periodic,
  input  logic [csr_pkg::xlen-3:0]       tcfg_initval,
  input  logic [csr_pkg::xlen-1:0]       tval,
  output logic [csr_pkg::xlen-1:0]       csr_rd_value
);

  always_comb begin
    case (csr_num)
      csr_pkg::csr_crmd:   csr_rd_value = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                           crmd_ie, crmd_plv};
      csr_pkg::csr_prmd:   csr_rd_value = {29'b0, prmd_pie, prmd_pplv};
      csr_pkg::csr_ecfg:   csr_rd_value = {19'b0, ecfg_lie};
      csr_pkg::csr_estat:  csr_rd_value = {1'b0, estat_esubcode, estat_ecode, 3'b0, 1'b0,
                                           timer_int, 1'b0, 8'b0, estat_is_sw}; // is[11] timer
      csr_pkg::csr_era:    csr_rd_value = era;
      csr_pkg::csr_badv:   csr_rd_value = badv;
      csr_pkg::csr_eentry: csr_rd_value = eentry;
      csr_pkg::csr_save0:  csr_rd_value = save0;
      csr_pkg::csr_save1:  csr_rd_value = save1;
      csr_pkg::csr_save2:  csr_rd_value = save2;
      csr_pkg::csr_save3:  csr_rd_value = save3;
      csr_pkg::csr_tid:    csr_rd_value = tid;
      csr_pkg::csr_tcfg:   csr_rd_value = {tcfg_initval, tcfg_periodic, tcfg_en};
      csr_pkg::csr_tval:   csr_rd_value = tval;
      default:             csr_rd_value = '0; // ticlr and unknown numbers
    endcase
  end

endmodule

`default_nettype wire

//--- src/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
  input  logic                           csr_we,
  input  logic [csr_pkg::xlen-1:0]       csr_wvalue,
  input  logic [csr_pkg::xlen-1:0]       csr_wmask,
  input  logic                           wb_ex,
  input  logic                           ertn_flush,
  input  logic [csr_pkg::ecode_w-1:0]    wb_ecode,
  input  logic [csr_pkg::esubcode_w-1:0] wb_esubcode,
  input  logic [csr_pkg::xlen-1:0]       wb_pc,
  input  logic [csr_pkg::xlen-1:0]       wb_badv,
  input  logic                           exc_if,
  output logic [csr_pkg::xlen-1:0]       csr_rd_value,
  output logic                           csr_is_branch,
  output logic [csr_pkg::xlen-1:0]       csr_pc_if,
  output logic [1:0]                     csr_plv,
  output logic                           has_int
);

  logic                           crmd_ie;
  logic                           crmd_da;
  logic                           crmd_pg;
  logic [1:0]                     crmd_datf;
  logic [1:0]                     crmd_datm;
  logic [1:0]                     prmd_pplv;
  logic                           prmd_pie;
  logic [csr_pkg::lie_w-1:0]      ecfg_lie;
  logic [1:0]                     estat_is_sw;
  logic                           timer_int;
  logic [csr_pkg::ecode_w-1:0]    estat_ecode;
  logic [csr_pkg::esubcode_w-1:0] estat_esubcode;
  logic [csr_pkg::xlen-1:0]       era;
  logic [csr_pkg::xlen-1:0]       eentry;
  logic [csr_pkg::xlen-1:0]       badv;
  logic [csr_pkg::xlen-1:0]       save0;
  logic [csr_pkg::xlen-1:0]       save1;
  logic [csr_pkg::xlen-1:0]       save2;
  logic [csr_pkg::xlen-1:0]       save3;
  logic [csr_pkg::xlen-1:0]       tid;
  logic                           tcfg_en;
  logic                           tcfg_periodic;
  logic [csr_pkg::xlen-3:0]       tcfg_initval;
  logic [csr_pkg::xlen-1:0]       tval;

  csr_mode_regs i_mode_regs (
    .clk         (clk),
    .reset       (reset),
    .csr_num     (csr_num),
    .csr_we      (csr_we),
    .csr_wvalue  (csr_wvalue),
    .csr_wmask   (csr_wmask),
    .wb_ex       (wb_ex),
    .ertn_flush  (ertn_flush),
    .timer_int   (timer_int),
    .crmd_plv    (csr_plv),
    .crmd_ie     (crmd_ie),
    .crmd_da     (crmd_da),
    .crmd_pg     (crmd_pg),
    .crmd_datf   (crmd_datf),
    .crmd_datm   (crmd_datm),
    .prmd_pplv   (prmd_pplv),
    .prmd_pie    (prmd_pie),
    .ecfg_lie    (ecfg_lie),
    .estat_is_sw (estat_is_sw),
    .has_int     (has_int)
  );

  csr_exc_regs i_exc_regs (
    .clk            (clk),
    .reset          (reset),
    .csr_num        (csr_num),
    .csr_we         (csr_we),
    .csr_wvalue     (csr_wvalue),
    .csr_wmask      (csr_wmask),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .wb_ecode       (wb_ecode),
    .wb_esubcode    (wb_esubcode),
    .wb_pc          (wb_pc),
    .wb_badv        (wb_badv),
    .exc_if         (exc_if),
    .estat_ecode    (estat_ecode),
    .estat_esubcode (estat_esubcode),
    .era            (era),
    .eentry         (eentry),
    .badv           (badv),
    .save0          (save0),
    .save1          (save1),
    .save2          (save2),
    .save3          (save3),
    .csr_is_branch  (csr_is_branch),
    .csr_pc_if      (csr_pc_if)
  );

  csr_timer i_timer (
    .clk           (clk),
    .reset         (reset),
    .csr_num       (csr_num),
    .csr_we        (csr_we),
    .csr_wvalue    (csr_wvalue),
    .csr_wmask     (csr_wmask),
    .tid           (tid),
    .tcfg_en       (tcfg_en),
    .tcfg_periodic (tcfg_periodic),
    .tcfg_initval  (tcfg_initval),
    .tval          (tval),
    .timer_int     (timer_int)
  );

  csr_read_mux i_read_mux (
    .csr_num        (csr_num),
    .crmd_plv       (csr_plv),
    .crmd_ie        (crmd_ie),
    .crmd_da        (crmd_da),
    .crmd_pg        (crmd_pg),
    .crmd_datf      (crmd_datf),
    .crmd_datm      (crmd_datm),
    .prmd_pplv      (prmd_pplv),
    .prmd_pie       (prmd_pie),
    .ecfg_lie       (ecfg_lie),
    .estat_is_sw    (estat_is_sw),
    .timer_int      (timer_int),
    .estat_ecode    (estat_ecode),
    .estat_esubcode (estat_esubcode),
    .era            (era),
    .eentry         (eentry),
    .badv           (badv),
    .save0          (save0),
    .save1          (save1),
    .save2          (save2),
    .save3          (save3),
    .tid            (tid),
    .tcfg_en        (tcfg_en),
    .tcfg_periodic  (tcfg_periodic),
    .tcfg_initval   (tcfg_initval),
    .tval           (tval),
    .csr_rd_value   (csr_rd_value)
  );

endmodule

`default_nettype wire

//--- tb/csr_test_table.svh
// columns: kind, csr number, value (subcode or timeout), mask, ecode, pc, badv, exc_if,
// expected value
localparam int n_rows = 48;

logic [31:0] test_rows [n_rows][9] = '{
  '{k_read, csr_pkg::csr_crmd, 0, 0, 0, 0, 0, 0, 32'h0000_0008},
  '{k_read, csr_pkg::csr_tval, 0, 0, 0, 0, 0, 0, 32'hffff_ffff},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 0},
  '{k_wrnd, csr_pkg::csr_save0, 0, 32'hffff_ffff, 0, 0, 0, 0, 0},
  '{k_wrnd, csr_pkg::csr_save1, 0, 32'h0000_ffff, 0, 0, 0, 0, 0},
  '{k_wrnd, csr_pkg::csr_save2, 0, 32'hf0f0_f0f0, 0, 0, 0, 0, 0},
  '{k_wrnd, csr_pkg::csr_save3, 0, 32'hffff_ffff, 0, 0, 0, 0, 0},
  '{k_wrnd, csr_pkg::csr_save3, 0, 32'h00ff_00ff, 0, 0, 0, 0, 0},
  '{k_rmodel, csr_pkg::csr_save0, 0, 0, 0, 0, 0, 0, 0},
  '{k_rmodel, csr_pkg::csr_save1, 0, 0, 0, 0, 0, 0, 0},
  '{k_rmodel, csr_pkg::csr_save2, 0, 0, 0, 0, 0, 0, 0},
  '{k_rmodel, csr_pkg::csr_save3, 0, 0, 0, 0, 0, 0, 0},
  '{k_write, csr_pkg::csr_era, 32'h1234_5678, 32'hffff_0000, 0, 0, 0, 0, 0},
  '{k_write, csr_pkg::csr_era, 32'haaaa_5555, 32'h0000_ffff, 0, 0, 0, 0, 0},
  '{k_read, csr_pkg::csr_era, 0, 0, 0, 0, 0, 0, 32'h1234_5555},
  '{k_write, csr_pkg::csr_eentry, 32'h1c00_0fff, 32'hffff_ffff, 0, 0, 0, 0, 0},
  '{k_read, csr_pkg::csr_eentry, 0, 0, 0, 0, 0, 0, 32'h1c00_0fc0}, // low 6 bits dropped
  '{k_write, csr_pkg::csr_crmd, 32'h7, 32'h7, 0, 0, 0, 0, 0},      // plv 3, ie 1
  '{k_read, csr_pkg::csr_crmd, 0, 0, 0, 0, 0, 0, 32'h0000_000f},
  '{k_exc, 0, 32'h1, 0, 9, 32'h1c00_1234, 32'h0000_beef, 0, 32'h1c00_0fc0},
  '{k_read, csr_pkg::csr_era, 0, 0, 0, 0, 0, 0, 32'h1c00_1234},
  '{k_read, csr_pkg::csr_badv, 0, 0, 0, 0, 0, 0, 32'h0000_beef},
  '{k_read, csr_pkg::csr_estat, 0, 0, 0, 0, 0, 0, 32'h0049_0000},
  '{k_read, csr_pkg::csr_prmd, 0, 0, 0, 0, 0, 0, 32'h0000_0007},
  '{k_read, csr_pkg::csr_crmd, 0, 0, 0, 0, 0, 0, 32'h0000_0008},
  '{k_ertn, 0, 0, 0, 0, 0, 0, 0, 32'h1c00_1234},
  '{k_read, csr_pkg::csr_crmd, 0, 0, 0, 0, 0, 0, 32'h0000_000f},
  '{k_pc, 0, 0, 0, 0, 32'h1c00_2000, 0, 0, 32'h1c00_2004},
  '{k_write, csr_pkg::csr_tcfg, 32'hd, 32'hffff_ffff, 0, 0, 0, 0, 0}, // initval 3, one-shot
  '{k_read, csr_pkg::csr_tval, 0, 0, 0, 0, 0, 0, 32'h0000_000c},
  '{k_read, csr_pkg::csr_tval, 0, 0, 0, 0, 0, 0, 32'h0000_000b},
  '{k_wait, csr_pkg::csr_estat, 40, 0, 0, 0, 0, 0, 32'h0000_0800},
  '{k_read, csr_pkg::csr_tval, 0, 0, 0, 0, 0, 0, 32'hffff_ffff},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 0},
  '{k_write, csr_pkg::csr_crmd, 32'h0, 32'h4, 0, 0, 0, 0, 0},
  '{k_write, csr_pkg::csr_ecfg, 32'h800, 32'hffff_ffff, 0, 0, 0, 0, 0},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 0},
  '{k_write, csr_pkg::csr_crmd, 32'h4, 32'h4, 0, 0, 0, 0, 0},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 1},
  '{k_write, csr_pkg::csr_ticlr, 32'h1, 32'h1, 0, 0, 0, 0, 0},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 0},
  '{k_read, csr_pkg::csr_estat, 0, 0, 0, 0, 0, 0, 32'h0049_0000},
  '{k_write, csr_pkg::csr_tcfg, 32'hb, 32'hffff_ffff, 0, 0, 0, 0, 0}, // initval 2, periodic
  '{k_wait, csr_pkg::csr_estat, 40, 0, 0, 0, 0, 0, 32'h0000_0800},
  '{k_write, csr_pkg::csr_ticlr, 32'h1, 32'h1, 0, 0, 0, 0, 0},
  '{k_read, csr_pkg::csr_estat, 0, 0, 0, 0, 0, 0, 32'h0049_0000},   // flag clear again
  '{k_wait, csr_pkg::csr_estat, 40, 0, 0, 0, 0, 0, 32'h0000_0800},
  '{k_int, 0, 0, 0, 0, 0, 0, 0, 1}
};

//--- tb/tb_csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csr_unit;

  localparam int k_write = 0; // masked write
  localparam int k_wrnd = 1;  // masked write of random data, tracked in save_model
  localparam int k_read = 2;
  localparam int k_rmodel = 3; // read compared with save_model
  localparam int k_exc = 4;
  localparam int k_ertn = 5;
  localparam int k_pc = 6;    // no strobe, fall-through pc
  localparam int k_int = 7;
  localparam int k_wait = 8;  // poll read word until expected bits are set

  logic                           clk;
  logic                           reset;
  logic [csr_pkg::csr_num_w-1:0]  csr_num;
  logic                           csr_we;
  logic [csr_pkg::xlen-1:0]       csr_wvalue;
  logic [csr_pkg::xlen-1:0]       csr_wmask;
  logic                           wb_ex;
  logic                           ertn_flush;
  logic [csr_pkg::ecode_w-1:0]    wb_ecode;
  logic [csr_pkg::esubcode_w-1:0] wb_esubcode;
  logic [csr_pkg::xlen-1:0]       wb_pc;
  logic [csr_pkg::xlen-1:0]       wb_badv;
  logic                           exc_if;
  logic [csr_pkg::xlen-1:0]       csr_rd_value;
  logic                           csr_is_branch;
  logic [csr_pkg::xlen-1:0]       csr_pc_if;
  logic [1:0]                     csr_plv;
  logic                           has_int;

  int          errors;
  int          failed_tests;
  logic [31:0] save_model [4];

  `include "csr_test_table.svh"

  csr_unit i_dut (
    .clk           (clk),
    .reset         (reset),
    .csr_num       (csr_num),
    .csr_we        (csr_we),
    .csr_wvalue    (csr_wvalue),
    .csr_wmask     (csr_wmask),
    .wb_ex         (wb_ex),
    .ertn_flush    (ertn_flush),
    .wb_ecode      (wb_ecode),
    .wb_esubcode   (wb_esubcode),
    .wb_pc         (wb_pc),
    .wb_badv       (wb_badv),
    .exc_if        (exc_if),
    .csr_rd_value  (csr_rd_value),
    .csr_is_branch (csr_is_branch),
    .csr_pc_if     (csr_pc_if),
    .csr_plv       (csr_plv),
    .has_int       (has_int)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // new bits where mask is set, old bits elsewhere
  function automatic logic [31:0] merge_expected(input logic [31:0] old_value,
                                                 input logic [31:0] new_value,
                                                 input logic [31:0] mask);
    return (old_value & ~mask) | (new_value & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic drive_idle();
    csr_we = 1'b0;
    wb_ex = 1'b0;
    ertn_flush = 1'b0;
  endtask

  task automatic wait_for_bits(input logic [31:0] bits, input int timeout);
    int cycles;
    cycles = 0;
    while ((csr_rd_value & bits) !== bits && cycles < timeout) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if ((csr_rd_value & bits) !== bits) begin
      $display("Timeout: bits %h of CSR %h still clear after %0d cycles", bits, csr_num,
               timeout);
      errors++;
    end
  endtask

  initial begin
    int          row_errors;
    int          kind;
    logic [31:0] value;
    void'($urandom(65826));
    errors = 0;
    failed_tests = 0;
    for (int j = 0; j < 4; j++)
      save_model[j] = '0;
    reset = 1'b1;
    csr_num = '0;
    csr_wvalue = '0;
    csr_wmask = '0;
    wb_ecode = '0;
    wb_esubcode = '0;
    wb_pc = '0;
    wb_badv = '0;
    exc_if = 1'b0;
    drive_idle();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);
      drive_idle();
      row_errors = errors;
      kind = test_rows[i][0];
      csr_num = test_rows[i][1][csr_pkg::csr_num_w-1:0];
      value = test_rows[i][2];
      case (kind)
        k_write, k_wrnd: begin
          if (kind == k_wrnd) begin
            value = $urandom;
            save_model[csr_num[1:0]] = merge_expected(save_model[csr_num[1:0]], value,
                                                      test_rows[i][3]);
          end
          csr_we = 1'b1;
          csr_wvalue = value;
          csr_wmask = test_rows[i][3];
        end
        k_exc: begin
          wb_ex = 1'b1;
          wb_ecode = test_rows[i][4][csr_pkg::ecode_w-1:0];
          wb_esubcode = value[csr_pkg::esubcode_w-1:0]; // subcode rides in the value column
          wb_pc = test_rows[i][5];
          wb_badv = test_rows[i][6];
          exc_if = test_rows[i][7][0];
        end
        k_ertn: ertn_flush = 1'b1;
        k_pc: wb_pc = test_rows[i][5];
        default: ;
      endcase
      #1;
      case (kind)
        k_read: begin
          check_value("csr_rd_value", csr_rd_value, test_rows[i][8]);
          if (csr_num == csr_pkg::csr_crmd) // plv port mirrors crmd[1:0]
            check_value("csr_plv", {30'b0, csr_plv}, {30'b0, test_rows[i][8][1:0]});
        end
        k_rmodel: check_value("csr_rd_value", csr_rd_value, save_model[csr_num[1:0]]);
        k_exc, k_ertn, k_pc: begin
          check_value("csr_is_branch", {31'b0, csr_is_branch}, {31'b0, kind != k_pc});
          check_value("csr_pc_if", csr_pc_if, test_rows[i][8]);
        end
        k_int: check_value("has_int", {31'b0, has_int}, test_rows[i][8]);
        k_wait: wait_for_bits(test_rows[i][8], value);
        default: ;
      endcase
      if (errors != row_errors)
        failed_tests++;
      $display("test %0d, csr %h: %s", i, csr_num, (errors == row_errors) ? "ok" : "failed");
    end

    $display("%0d tests, %0d failed, %0d errors", n_rows, failed_tests, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
src/csr_pkg.sv
src/csr_mode_regs.sv
src/csr_exc_regs.sv
src/csr_timer.sv
src/csr_read_mux.sv
src/csr_unit.sv
tb/tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/csr_mode_regs.sv
  - src/csr_exc_regs.sv
  - src/csr_timer.sv
  - src/csr_read_mux.sv
  - src/csr_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_csr_unit.sv
